// ==== Bender.yml ====
package:
  name: icache

sources:
  - source/icache_pkg.sv
  - source/icache_ctrl.sv
  - source/icache_repl.sv
  - source/icache_store.sv
  - source/icache_top.sv
  - target: test
    files:
      - dv/icache_clk_gen.sv
      - dv/icache_props.sv
      - dv/icache_tb.sv

// ==== dv/icache_clk_gen.sv ====
// free running testbench clock, period of 40 time units
module icache_clk_gen (
  output logic clk_o
);

  // half period of 20 gives the 40 unit cycle
  initial begin
    clk_o = 1'b0;
    forever begin
      #20 clk_o = ~clk_o;
    end
  end

endmodule

// ==== dv/icache_props.sv ====
// concurrent checks on the fetch controller
// bound into every icache_ctrl instance
module icache_props (
  input logic                    clk_i,
  input logic                    rst_ni,
  input icache_pkg::ctrl_state_e state_i,
  input logic                    fetch_ready_i,
  input logic                    fetch_valid_i,
  input logic                    refill_req_i
);

  // next states the fsm may reach from each state
  function automatic logic legal_step(icache_pkg::ctrl_state_e prev,
                                      icache_pkg::ctrl_state_e cur);
    case (prev)
      icache_pkg::FLUSH: return cur inside {icache_pkg::FLUSH, icache_pkg::IDLE};
      icache_pkg::IDLE:  return cur inside {icache_pkg::IDLE, icache_pkg::FLUSH,
                                            icache_pkg::READ};
      icache_pkg::READ:  return cur inside {icache_pkg::READ, icache_pkg::IDLE,
                                            icache_pkg::MISS};
      icache_pkg::MISS:  return cur inside {icache_pkg::MISS, icache_pkg::IDLE};
      default:           return 1'b0;
    endcase
  endfunction

  // state is always known and only moves along the fsm arcs
  state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(state_i) && legal_step($past(state_i), state_i))
    else $error("controller state is unknown or took an illegal transition");

  // a result never shows up while a refill request is still waiting for its ack
  no_valid_in_refill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(fetch_valid_i && refill_req_i))
    else $error("fetch_valid_o raised while refill_req_o is pending");

  // the set walk blocks new fetches
  no_ready_in_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == icache_pkg::FLUSH) |-> !fetch_ready_i)
    else $error("fetch_ready_o high during the flush walk");

endmodule

bind icache_ctrl icache_props u_icache_props (
  .clk_i         ( clk_i         ),
  .rst_ni        ( rst_ni        ),
  .state_i       ( state_q       ),
  .fetch_ready_i ( fetch_ready_o ),
  .fetch_valid_i ( fetch_valid_o ),
  .refill_req_i  ( refill_req_o  )
);

// ==== dv/icache_tb.sv ====
// testbench for the instruction cache
// random fetches against a memory model, checked with a resident-line model per epoch
module icache_tb;

  localparam int unsigned POOL_SIZE    = 24;
  localparam int unsigned ACCEPT_LIMIT = 64;
  localparam int unsigned RESULT_LIMIT = 64;
  localparam int unsigned CLEAR_LIMIT  = 64;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     en_i;
  logic                     flush_i;
  logic                     fetch_req_i;
  icache_pkg::addr_t        fetch_addr_i;
  logic                     fetch_ready_o;
  logic                     fetch_valid_o;
  icache_pkg::word_t        fetch_data_o;
  logic                     refill_req_o;
  icache_pkg::refill_req_t  refill_o;
  logic                     refill_ack_i;
  logic                     refill_vld_i;
  icache_pkg::refill_rtrn_t refill_rtrn_i;
  logic                     miss_o;

  // fetch side values, applied at the next falling edge
  logic                    req_drv, en_drv, flush_drv;
  icache_pkg::addr_t       addr_drv;
  // memory model
  logic                    mem_busy;
  int unsigned             ack_wait;
  int unsigned             rtn_wait;
  icache_pkg::addr_t       mem_addr;
  // what happened during the current fetch
  int unsigned             refill_cnt;
  int unsigned             miss_cnt;
  icache_pkg::refill_req_t last_refill;
  logic                    in_flight;
  // reference model, resident lines of the current epoch
  logic                    enabled;
  logic                    predict;
  icache_pkg::addr_t       resident_q[$];
  icache_pkg::addr_t       pool[POOL_SIZE];

  icache_clk_gen u_clk_gen (
    .clk_o ( clk_i )
  );

  icache_top u_icache_top (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .en_i          ( en_i          ),
    .flush_i       ( flush_i       ),
    .fetch_req_i   ( fetch_req_i   ),
    .fetch_addr_i  ( fetch_addr_i  ),
    .fetch_ready_o ( fetch_ready_o ),
    .fetch_valid_o ( fetch_valid_o ),
    .fetch_data_o  ( fetch_data_o  ),
    .refill_req_o  ( refill_req_o  ),
    .refill_o      ( refill_o      ),
    .refill_ack_i  ( refill_ack_i  ),
    .refill_vld_i  ( refill_vld_i  ),
    .refill_rtrn_i ( refill_rtrn_i ),
    .miss_o        ( miss_o        )
  );

  ////////////////////
  // memory contents
  ////////////////////

  // fixed scramble of the word address
  function automatic icache_pkg::word_t mem_word(icache_pkg::addr_t addr);
    icache_pkg::word_t wa;
    wa = addr >> icache_pkg::BYTE_SEL_WIDTH;
    return (wa * 32'h9E37_79B1) ^ {wa[15:0], wa[31:16]} ^ 32'h5A3C_C3A5;
  endfunction

  // word 0 sits in the low bits of the line
  function automatic icache_pkg::line_t build_line(icache_pkg::addr_t addr);
    icache_pkg::line_t line;
    icache_pkg::addr_t base;
    base = addr;
    base[icache_pkg::OFFSET_WIDTH-1:0] = '0;
    for (int i = 0; i < icache_pkg::LINE_WIDTH / icache_pkg::FETCH_WIDTH; i++) begin
      line[i*icache_pkg::FETCH_WIDTH +: icache_pkg::FETCH_WIDTH] =
        mem_word(base + icache_pkg::addr_t'(i * icache_pkg::FETCH_WIDTH / 8));
    end
    return line;
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(icache_pkg::word_t got, icache_pkg::word_t exp, string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_addr(icache_pkg::addr_t got, icache_pkg::addr_t exp, string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_miss(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_cycles(int unsigned got, int unsigned exp, string what);
    if (got != exp) begin
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      stop_run();
    end
  endtask

  ////////////////////
  // cycle step
  ////////////////////

  // memory acks after 0..3 cycles and returns 1..6 cycles after the ack
  task automatic drive_memory();
    refill_ack_i  = 1'b0;
    refill_vld_i  = 1'b0;
    refill_rtrn_i = '0;
    if (mem_busy) begin
      if (rtn_wait == 0) begin
        refill_vld_i       = 1'b1;
        refill_rtrn_i.line = build_line(mem_addr);
        mem_busy           = 1'b0;
      end else begin
        rtn_wait--;
      end
    end else if (refill_req_o) begin
      if (ack_wait == 0) begin
        refill_ack_i = 1'b1;
        mem_addr     = refill_o.addr;
        last_refill  = refill_o;
        mem_busy     = 1'b1;
        refill_cnt++;
        rtn_wait     = $urandom_range(5, 0);
        ack_wait     = $urandom_range(3, 0);
      end else begin
        ack_wait--;
      end
    end
  endtask

  // drive on the falling edge, sample once the cycle has settled
  task automatic step();
    @(negedge clk_i);
    drive_memory();
    fetch_req_i  = req_drv;
    fetch_addr_i = addr_drv;
    en_i         = en_drv;
    flush_i      = flush_drv;
    #1;
    if (fetch_valid_o && !in_flight) begin
      $display("fetch_valid_o pulsed at %0t with no fetch outstanding", $time);
      stop_run();
    end
    if (miss_o) begin
      miss_cnt++;
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic is_resident(icache_pkg::addr_t line_addr);
    foreach (resident_q[i]) begin
      if (resident_q[i] == line_addr) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  function automatic icache_pkg::addr_t word_in_line(icache_pkg::addr_t line_addr);
    icache_pkg::addr_t a;
    a = line_addr;
    a[icache_pkg::OFFSET_WIDTH-1:0] = icache_pkg::offset_t'(
      $urandom_range(icache_pkg::LINE_WIDTH / icache_pkg::FETCH_WIDTH - 1, 0)
      << icache_pkg::BYTE_SEL_WIDTH);
    return a;
  endfunction

  // working set, never more lines per set than there are ways
  task automatic build_pool();
    int unsigned       filled;
    int unsigned       in_set;
    logic              dup;
    icache_pkg::addr_t cand;
    filled = 0;
    while (filled < POOL_SIZE) begin
      cand = $urandom;
      cand[icache_pkg::NC_BIT] = 1'b0;
      cand[icache_pkg::OFFSET_WIDTH-1:0] = '0;
      in_set = 0;
      dup    = 1'b0;
      for (int i = 0; i < filled; i++) begin
        if (pool[i] == cand) begin
          dup = 1'b1;
        end
        if (pool[i][icache_pkg::OFFSET_WIDTH +: icache_pkg::INDEX_WIDTH] ==
            cand[icache_pkg::OFFSET_WIDTH +: icache_pkg::INDEX_WIDTH]) begin
          in_set++;
        end
      end
      if (!dup && in_set < icache_pkg::NUM_WAYS) begin
        pool[filled] = cand;
        filled++;
      end
    end
  endtask

  // mostly working-set lines, one in eight goes to the i/o region
  function automatic icache_pkg::addr_t pick_addr();
    icache_pkg::addr_t a;
    if ($urandom_range(7, 0) == 0) begin
      a = $urandom;
      a[icache_pkg::NC_BIT] = 1'b1;
      a[icache_pkg::BYTE_SEL_WIDTH-1:0] = '0;
    end else begin
      a = word_in_line(pool[$urandom_range(POOL_SIZE - 1, 0)]);
    end
    return a;
  endfunction

  // sixteen tags folded onto four sets, far beyond what four ways hold
  function automatic icache_pkg::addr_t evict_addr();
    icache_pkg::addr_t a;
    a = '0;
    a[icache_pkg::ADDR_WIDTH-1 -: icache_pkg::TAG_WIDTH] =
      icache_pkg::tag_t'($urandom_range(15, 0));
    a[icache_pkg::OFFSET_WIDTH +: icache_pkg::INDEX_WIDTH] =
      icache_pkg::set_idx_t'($urandom_range(3, 0));
    return word_in_line(a);
  endfunction

  ////////////////////
  // sequences
  ////////////////////

  // one fetch from request to result, hit or miss predicted unless traffic evicts
  task automatic fetch_one(icache_pkg::addr_t addr);
    logic              nc;
    logic              known;
    logic              exp_hit;
    logic              first_req;
    logic              got_refill;
    int unsigned       wait_cnt;
    int unsigned       lat;
    icache_pkg::addr_t line_addr;
    icache_pkg::addr_t word_addr;
    nc        = addr[icache_pkg::NC_BIT] | ~enabled;
    line_addr = addr;
    line_addr[icache_pkg::OFFSET_WIDTH-1:0] = '0;
    word_addr = addr;
    word_addr[icache_pkg::BYTE_SEL_WIDTH-1:0] = '0;
    exp_hit   = ~nc & is_resident(line_addr);
    // uncached fetches never hit, so they are always predictable
    known     = predict | nc;
    repeat ($urandom_range(2, 0)) begin
      step();
    end
    req_drv  = 1'b1;
    addr_drv = addr;
    wait_cnt = 0;
    step();
    while (!fetch_ready_o) begin
      if (wait_cnt == ACCEPT_LIMIT) begin
        $display("fetch of %h was not accepted within %0d cycles", addr, ACCEPT_LIMIT);
        stop_run();
      end
      wait_cnt++;
      step();
    end
    // accepted at the coming rising edge
    req_drv    = 1'b0;
    in_flight  = 1'b1;
    refill_cnt = 0;
    miss_cnt   = 0;
    lat        = 1;
    step();
    first_req  = refill_req_o;
    while (!fetch_valid_o) begin
      if (lat == RESULT_LIMIT) begin
        $display("no fetch_valid_o within %0d cycles after accepting %h", RESULT_LIMIT, addr);
        stop_run();
      end
      lat++;
      step();
    end
    in_flight = 1'b0;
    check_word(fetch_data_o, mem_word(addr), "fetch_data_o");
    if (refill_cnt > 1 || miss_cnt > 1) begin
      $display("fetch of %h issued %0d refills and %0d miss pulses", addr, refill_cnt, miss_cnt);
      stop_run();
    end
    got_refill = (refill_cnt != 0);
    if (known) begin
      check_flag(got_refill, ~exp_hit, "refill issued");
    end
    // miss_o counts cacheable refills only
    check_miss(miss_cnt != 0, got_refill & ~nc, "miss_o pulse");
    if (got_refill) begin
      check_flag(first_req, 1'b1, "refill_req_o one cycle after accept");
      check_addr(last_refill.addr, nc ? word_addr : line_addr, "refill address");
      check_flag(last_refill.nc, nc, "refill nc flag");
    end else begin
      check_cycles(lat, 1, "hit latency");
    end
    if (predict && !nc && !exp_hit) begin
      resident_q.push_back(line_addr);
    end
  endtask

  // flush pulse or enable rise, then the walk over every set
  task automatic clear_cache(logic use_flush);
    int unsigned low_cnt;
    if (use_flush) begin
      flush_drv = 1'b1;
    end else begin
      en_drv = 1'b1;
    end
    step();
    flush_drv = 1'b0;
    check_flag(fetch_ready_o, 1'b0, "fetch_ready_o when the clear is requested");
    low_cnt = 0;
    step();
    while (!fetch_ready_o) begin
      if (low_cnt == CLEAR_LIMIT) begin
        $display("fetch_ready_o still low %0d cycles into the clear", CLEAR_LIMIT);
        stop_run();
      end
      low_cnt++;
      step();
    end
    check_cycles(low_cnt, icache_pkg::NUM_SETS, "fetch_ready_o low cycles of the clear");
    resident_q.delete();
    enabled = en_drv;
  endtask

  ////////////////////
  // main
  ////////////////////

  initial begin
    rst_ni        = 1'b0;
    en_i          = 1'b0;
    flush_i       = 1'b0;
    fetch_req_i   = 1'b0;
    fetch_addr_i  = '0;
    refill_ack_i  = 1'b0;
    refill_vld_i  = 1'b0;
    refill_rtrn_i = '0;
    req_drv       = 1'b0;
    en_drv        = 1'b0;
    flush_drv     = 1'b0;
    addr_drv      = '0;
    mem_busy      = 1'b0;
    ack_wait      = 0;
    rtn_wait      = 0;
    mem_addr      = '0;
    refill_cnt    = 0;
    miss_cnt      = 0;
    last_refill   = '0;
    in_flight     = 1'b0;
    enabled       = 1'b0;
    predict       = 1'b1;
    void'($urandom(45));
    repeat (5) begin
      @(negedge clk_i);
    end
    rst_ni = 1'b1;
    step();
    check_flag(fetch_ready_o, 1'b1, "fetch_ready_o after reset");
    check_flag(fetch_valid_o, 1'b0, "fetch_valid_o after reset");
    check_flag(refill_req_o, 1'b0, "refill_req_o after reset");
    check_miss(miss_o, 1'b0, "miss_o after reset");
    // disabled after reset, one line fetched again and again
    for (int i = 0; i < 8; i++) begin
      fetch_one(word_in_line(32'h0000_4560));
    end
    build_pool();
    clear_cache(1'b0);
    for (int i = 0; i < 160; i++) begin
      fetch_one(pick_addr());
    end
    // every line resident before the flush misses once more
    clear_cache(1'b1);
    foreach (pool[i]) begin
      fetch_one(word_in_line(pool[i]));
    end
    for (int i = 0; i < 60; i++) begin
      fetch_one(pick_addr());
    end
    // eviction traffic, only data and refill form are checked
    predict = 1'b0;
    for (int i = 0; i < 200; i++) begin
      fetch_one(evict_addr());
    end
    en_drv = 1'b0;
    step();
    enabled = 1'b0;
    for (int i = 0; i < 6; i++) begin
      fetch_one(word_in_line(pool[0]));
    end
    // switching back on starts a new epoch
    clear_cache(1'b0);
    predict = 1'b1;
    foreach (pool[i]) begin
      fetch_one(word_in_line(pool[i]));
    end
    for (int i = 0; i < 60; i++) begin
      fetch_one(pick_addr());
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== source/icache_ctrl.sv ====
// fetch controller of the instruction cache
// accepts fetches, sequences lookup, refill and flush, and drives the arrays
module icache_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     en_i,
  input  logic                     flush_i,
  // fetch port
  input  logic                     fetch_req_i,
  input  icache_pkg::addr_t        fetch_addr_i,
  output logic                     fetch_ready_o,
  output logic                     fetch_valid_o,
  output icache_pkg::word_t        fetch_data_o,
  // line store
  input  logic                     hit_i,
  input  icache_pkg::word_t        hit_data_i,
  output icache_pkg::store_req_t   store_req_o,
  output logic                     clear_o,
  output icache_pkg::set_idx_t     clear_idx_o,
  // replacement unit
  output logic                     cmp_en_o,
  output logic                     fill_o,
  // refill port
  output logic                     refill_req_o,
  output icache_pkg::refill_req_t  refill_o,
  input  logic                     refill_ack_i,
  input  logic                     refill_vld_i,
  input  icache_pkg::refill_rtrn_t refill_rtrn_i,
  // perf counter
  output logic                     miss_o
);

  icache_pkg::ctrl_state_e state_d, state_q;
  // cache is switched on
  logic                    cache_en_d, cache_en_q;
  // flush seen but not yet carried out
  logic                    flush_d, flush_q;
  // tag compare is meaningful in the next cycle
  logic                    cmp_en_d, cmp_en_q;
  logic                    nc_d, nc_q;
  icache_pkg::set_idx_t    flush_cnt_q;
  logic                    flush_done;
  icache_pkg::addr_t       addr_q;
  icache_pkg::addr_t       lookup_addr;
  logic                    accept;
  logic                    en_rise;
  logic                    hit_ok;
  logic                    wren;

  ////////////////////
  // address plumbing
  ////////////////////

  assign accept  = fetch_ready_o & fetch_req_i;
  // switching on always goes through a full clear first
  assign en_rise = en_i & ~cache_en_q;

  // i/o region or disabled cache goes down the miss path without allocating
  assign nc_d     = fetch_addr_i[icache_pkg::NC_BIT] | ~cache_en_q;
  // array lookup only for cacheable requests
  assign cmp_en_d = accept & ~nc_d;
  assign hit_ok   = cmp_en_q & hit_i;

  // new address on accept, else the latched one for the fill
  assign lookup_addr = accept ? fetch_addr_i : addr_q;

  assign store_req_o.rden    = cmp_en_d;
  assign store_req_o.wren    = wren;
  assign store_req_o.set_idx =
    lookup_addr[icache_pkg::OFFSET_WIDTH +: icache_pkg::INDEX_WIDTH];
  assign store_req_o.tag     =
    lookup_addr[icache_pkg::ADDR_WIDTH-1 -: icache_pkg::TAG_WIDTH];
  assign store_req_o.offset  = lookup_addr[icache_pkg::OFFSET_WIDTH-1:0];

  // nc requests ask for the word only, cacheable ones for the line
  assign refill_o.nc   = nc_q;
  assign refill_o.addr = nc_q ?
    {addr_q[icache_pkg::ADDR_WIDTH-1:icache_pkg::BYTE_SEL_WIDTH],
     {icache_pkg::BYTE_SEL_WIDTH{1'b0}}} :
    {addr_q[icache_pkg::ADDR_WIDTH-1:icache_pkg::OFFSET_WIDTH],
     {icache_pkg::OFFSET_WIDTH{1'b0}}};

  // hit word from the arrays, otherwise pick the word out of the returned line
  assign fetch_data_o = cmp_en_q ? hit_data_i :
    refill_rtrn_i.line[addr_q[icache_pkg::OFFSET_WIDTH-1:icache_pkg::BYTE_SEL_WIDTH] *
                       icache_pkg::FETCH_WIDTH +: icache_pkg::FETCH_WIDTH];

  // only cacheable refills count as a miss
  assign miss_o = refill_req_o & refill_ack_i & ~nc_q;

  ////////////////////
  // flush walk
  ////////////////////

  assign flush_done  = (flush_cnt_q == icache_pkg::set_idx_t'(icache_pkg::NUM_SETS - 1));
  assign clear_o     = (state_q == icache_pkg::FLUSH);
  assign clear_idx_o = flush_cnt_q;

  assign cmp_en_o = cmp_en_q;
  assign fill_o   = wren;

  ////////////////////
  // main fsm
  ////////////////////

  always_comb begin
    state_d       = state_q;
    // turning off is immediate, turning on waits for the clear
    cache_en_d    = cache_en_q & en_i;
    flush_d       = flush_q | flush_i;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    refill_req_o  = 1'b0;
    wren          = 1'b0;

    unique case (state_q)
      // one set cleared per cycle
      icache_pkg::FLUSH: begin
        if (flush_done) begin
          state_d    = icache_pkg::IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      icache_pkg::IDLE: begin
        // pending flush or enable wins over new fetches
        if (flush_d || en_rise) begin
          state_d = icache_pkg::FLUSH;
        end else begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            state_d = icache_pkg::READ;
          end
        end
      end
      icache_pkg::READ: begin
        if (hit_ok) begin
          fetch_valid_o = 1'b1;
          state_d       = icache_pkg::IDLE;
          // back to back accept on a hit, unless a clear is due
          if (!(flush_d || en_rise)) begin
            fetch_ready_o = 1'b1;
            if (fetch_req_i) begin
              state_d = icache_pkg::READ;
            end
          end
        end else begin
          // miss or nc, hold the request until memory takes it
          refill_req_o = 1'b1;
          if (refill_ack_i) begin
            state_d = icache_pkg::MISS;
          end
        end
      end
      icache_pkg::MISS: begin
        // return beat is consumed unconditionally
        if (refill_vld_i) begin
          fetch_valid_o = 1'b1;
          wren          = ~nc_q;
          state_d       = icache_pkg::IDLE;
        end
      end
      default: begin
        state_d = icache_pkg::IDLE;
      end
    endcase
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= icache_pkg::IDLE;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      cmp_en_q    <= 1'b0;
      nc_q        <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      flush_q    <= flush_d;
      cmp_en_q   <= cmp_en_d;
      if (accept) begin
        nc_q <= nc_d;
      end
      // wraps back to zero at the end of the walk
      if (state_q == icache_pkg::FLUSH) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
    end
  end

  // fetch address, held for the whole miss
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
  end

endmodule

// ==== source/icache_pkg.sv ====
// shared geometry, vector types and inter-module structs of the instruction cache
// every cache source file refers to these through icache_pkg:: scoped names
package icache_pkg;

  ////////////////////
  // geometry
  ////////////////////

  // physical address and fetch word
  localparam int unsigned ADDR_WIDTH     = 32;
  localparam int unsigned FETCH_WIDTH    = 32;
  // one line holds four fetch words
  localparam int unsigned LINE_WIDTH     = 128;
  localparam int unsigned NUM_WAYS       = 4;
  localparam int unsigned NUM_SETS       = 16;
  // byte offset inside a line
  localparam int unsigned OFFSET_WIDTH   = $clog2(LINE_WIDTH / 8);
  localparam int unsigned INDEX_WIDTH    = $clog2(NUM_SETS);
  // whatever is left above index and offset
  localparam int unsigned TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int unsigned WAY_IDX_WIDTH  = $clog2(NUM_WAYS);
  // byte select inside one fetch word, fetches are word aligned
  localparam int unsigned BYTE_SEL_WIDTH = $clog2(FETCH_WIDTH / 8);
  // upper half of the address space is uncached i/o
  localparam int unsigned NC_BIT         = 31;

  ////////////////////
  // vector types
  ////////////////////

  typedef logic [ADDR_WIDTH-1:0]    addr_t;
  typedef logic [FETCH_WIDTH-1:0]   word_t;
  typedef logic [LINE_WIDTH-1:0]    line_t;
  typedef logic [TAG_WIDTH-1:0]     tag_t;
  typedef logic [INDEX_WIDTH-1:0]   set_idx_t;
  typedef logic [OFFSET_WIDTH-1:0]  offset_t;
  // one bit per way, one-hot or plain mask
  typedef logic [NUM_WAYS-1:0]      way_oh_t;
  typedef logic [WAY_IDX_WIDTH-1:0] way_idx_t;

  ////////////////////
  // controller fsm
  ////////////////////

  // FLUSH walks all sets, READ is the lookup cycle, MISS waits for the fill
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

  ////////////////////
  // structs
  ////////////////////

  // lookup or fill command from the controller to the arrays
  typedef struct packed {
    logic     rden;
    logic     wren;
    set_idx_t set_idx;
    tag_t     tag;
    offset_t  offset;
  } store_req_t;

  // refill request towards memory
  // addr is line aligned for cacheable and word aligned for nc requests
  typedef struct packed {
    addr_t addr;
    logic  nc;
  } refill_req_t;

  // refill return, the whole line arrives in one beat
  typedef struct packed {
    line_t line;
  } refill_rtrn_t;

endpackage

// ==== source/icache_repl.sv ====
// victim way selection for the instruction cache
// fills an invalid way first, else a pseudo random one from an 8-bit lfsr
module icache_repl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  icache_pkg::way_oh_t  vld_i,
  input  logic                 cmp_en_i,
  input  logic                 fill_i,
  output icache_pkg::way_oh_t  victim_oh_o,
  output icache_pkg::way_idx_t victim_o
);

  logic [7:0]           lfsr_q;
  logic                 all_valid;
  icache_pkg::way_idx_t inv_way;
  icache_pkg::way_idx_t repl_way;
  icache_pkg::way_oh_t  victim_oh_q;

  // lowest numbered invalid way, scanned downwards so the lowest wins
  always_comb begin
    inv_way = '0;
    for (int i = icache_pkg::NUM_WAYS - 1; i >= 0; i--) begin
      if (!vld_i[i]) begin
        inv_way = icache_pkg::way_idx_t'(i);
      end
    end
  end

  assign all_valid = &vld_i;
  assign repl_way  = all_valid ? lfsr_q[icache_pkg::WAY_IDX_WIDTH-1:0] : inv_way;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q      <= 8'hA5;
      victim_oh_q <= '0;
    end else begin
      // x^8 + x^6 + x^5 + x^4 + 1, steps only when a full set is refilled
      if (fill_i && all_valid) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      end
      if (cmp_en_i) begin
        victim_oh_q <= icache_pkg::way_oh_t'(1) << repl_way;
      end
    end
  end

  assign victim_oh_o = victim_oh_q;

  // binary form of the registered victim
  always_comb begin
    victim_o = '0;
    for (int i = 0; i < icache_pkg::NUM_WAYS; i++) begin
      if (victim_oh_q[i]) begin
        victim_o = icache_pkg::way_idx_t'(i);
      end
    end
  end

endmodule

// ==== source/icache_store.sv ====
// tag, valid and line arrays of all ways with synchronous read
// compares the looked-up set against the registered tag and returns the hit word
module icache_store (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  icache_pkg::store_req_t req_i,
  input  logic                   clear_i,
  input  icache_pkg::set_idx_t   clear_idx_i,
  input  icache_pkg::way_oh_t    victim_oh_i,
  input  icache_pkg::line_t      wdata_i,
  output logic                   hit_o,
  output icache_pkg::word_t      hit_data_o,
  output icache_pkg::way_oh_t    vld_o
);

  // arrays, indexed by set then way
  icache_pkg::tag_t    tag_mem  [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];
  icache_pkg::line_t   line_mem [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];
  icache_pkg::way_oh_t vld_q    [icache_pkg::NUM_SETS];

  // read port registers
  icache_pkg::tag_t    tag_rd  [icache_pkg::NUM_WAYS];
  icache_pkg::line_t   line_rd [icache_pkg::NUM_WAYS];
  icache_pkg::way_oh_t vld_rd;
  // lookup tag and offset, kept for the compare cycle
  icache_pkg::tag_t    tag_q;
  icache_pkg::offset_t offset_q;

  icache_pkg::way_oh_t hit_way;

  ////////////////////
  // tag and line arrays
  ////////////////////

  always_ff @(posedge clk_i) begin
    // fill goes into the victim way only
    if (req_i.wren) begin
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
        if (victim_oh_i[w]) begin
          tag_mem[req_i.set_idx][w]  <= req_i.tag;
          line_mem[req_i.set_idx][w] <= wdata_i;
        end
      end
    end
    // lookup reads every way of the set
    if (req_i.rden) begin
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
        tag_rd[w]  <= tag_mem[req_i.set_idx][w];
        line_rd[w] <= line_mem[req_i.set_idx][w];
      end
      tag_q    <= req_i.tag;
      offset_q <= req_i.offset;
    end
  end

  ////////////////////
  // valid bits
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q  <= '{default: '0};
      vld_rd <= '0;
    end else begin
      // flush walk clears one whole set per cycle
      if (clear_i) begin
        vld_q[clear_idx_i] <= '0;
      end else if (req_i.wren) begin
        vld_q[req_i.set_idx] <= vld_q[req_i.set_idx] | victim_oh_i;
      end
      if (req_i.rden) begin
        vld_rd <= vld_q[req_i.set_idx];
      end
    end
  end

  assign vld_o = vld_rd;

  ////////////////////
  // compare and select
  ////////////////////

  always_comb begin
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      hit_way[w] = vld_rd[w] & (tag_rd[w] == tag_q);
    end
  end

  assign hit_o = |hit_way;

  // word of the lowest hitting way
  always_comb begin
    hit_data_o = '0;
    for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_way[w]) begin
        hit_data_o = line_rd[w][offset_q[icache_pkg::OFFSET_WIDTH-1:icache_pkg::BYTE_SEL_WIDTH] *
                                icache_pkg::FETCH_WIDTH +: icache_pkg::FETCH_WIDTH];
      end
    end
  end

endmodule

// ==== source/icache_top.sv ====
// instruction cache top level
// fetch port on one side, single-line refill port towards memory on the other
module icache_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     en_i,
  input  logic                     flush_i,
  // fetch port
  input  logic                     fetch_req_i,
  input  icache_pkg::addr_t        fetch_addr_i,
  output logic                     fetch_ready_o,
  output logic                     fetch_valid_o,
  output icache_pkg::word_t        fetch_data_o,
  // refill port
  output logic                     refill_req_o,
  output icache_pkg::refill_req_t  refill_o,
  input  logic                     refill_ack_i,
  input  logic                     refill_vld_i,
  input  icache_pkg::refill_rtrn_t refill_rtrn_i,
  // perf counter
  output logic                     miss_o
);

  icache_pkg::store_req_t store_req;
  logic                   clear;
  icache_pkg::set_idx_t   clear_idx;
  logic                   hit;
  icache_pkg::word_t      hit_data;
  icache_pkg::way_oh_t    set_vld;
  logic                   cmp_en;
  logic                   fill;
  icache_pkg::way_oh_t    victim_oh;

  icache_ctrl u_ctrl (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .en_i          ( en_i          ),
    .flush_i       ( flush_i       ),
    .fetch_req_i   ( fetch_req_i   ),
    .fetch_addr_i  ( fetch_addr_i  ),
    .fetch_ready_o ( fetch_ready_o ),
    .fetch_valid_o ( fetch_valid_o ),
    .fetch_data_o  ( fetch_data_o  ),
    .hit_i         ( hit           ),
    .hit_data_i    ( hit_data      ),
    .store_req_o   ( store_req     ),
    .clear_o       ( clear         ),
    .clear_idx_o   ( clear_idx     ),
    .cmp_en_o      ( cmp_en        ),
    .fill_o        ( fill          ),
    .refill_req_o  ( refill_req_o  ),
    .refill_o      ( refill_o      ),
    .refill_ack_i  ( refill_ack_i  ),
    .refill_vld_i  ( refill_vld_i  ),
    .refill_rtrn_i ( refill_rtrn_i ),
    .miss_o        ( miss_o        )
  );

  // fill data comes straight from the refill return
  icache_store u_store (
    .clk_i       ( clk_i              ),
    .rst_ni      ( rst_ni             ),
    .req_i       ( store_req          ),
    .clear_i     ( clear              ),
    .clear_idx_i ( clear_idx          ),
    .victim_oh_i ( victim_oh          ),
    .wdata_i     ( refill_rtrn_i.line ),
    .hit_o       ( hit                ),
    .hit_data_o  ( hit_data           ),
    .vld_o       ( set_vld            )
  );

  // binary victim is not needed at this level
  icache_repl u_repl (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .vld_i       ( set_vld   ),
    .cmp_en_i    ( cmp_en    ),
    .fill_i      ( fill      ),
    .victim_oh_o ( victim_oh ),
    .victim_o    (           )
  );

endmodule

// ==== tb.f ====
source/icache_pkg.sv
source/icache_ctrl.sv
source/icache_repl.sv
source/icache_store.sv
source/icache_top.sv
dv/icache_clk_gen.sv
dv/icache_props.sv
dv/icache_tb.sv
